//--- logic/board_pkg.sv
package board_pkg;

  //////////////////////////////
  // widths and vector types
  //////////////////////////////

  // pins brought out by the board wrapper
  localparam int NumGpio = 29;

  // one bit per gpio pin
  typedef logic [NumGpio-1:0] gpio_vec_t;

  // fan duty step, 0 to 15
  typedef logic [3:0] fan_duty_t;

  // byte address inside the register block
  typedef logic [11:0] apb_addr_t;

  // apb data word
  typedef logic [31:0] apb_data_t;

  //////////////////////////////
  // register map
  //////////////////////////////

  // read/write
  localparam apb_addr_t RegGpioOut = 12'h000;
  localparam apb_addr_t RegGpioEn  = 12'h004;
  // read only
  localparam apb_addr_t RegGpioIn  = 12'h008;
  localparam apb_addr_t RegFanDuty = 12'h00C;

  // read data on any errored access
  localparam apb_data_t ErrVal = 32'hBADCAB1E;

  //////////////////////////////
  // apb bundles
  //////////////////////////////

  // driven by the bus master
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // driven by the slave
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // apb slave states, one fixed wait state per transfer
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_wait    = 2'd1,
    st_respond = 2'd2
  } apb_state_t;

endpackage

//--- logic/gpio_sync.sv
`timescale 1ns/1ps

module gpio_sync
  import board_pkg::*;
#(
  parameter int SyncStages = 2
) (
  input  logic      soc_clk,
  input  logic      rst_n,
  input  gpio_vec_t gpio_i,
  input  fan_duty_t fan_sw_i,
  output gpio_vec_t gpio_sync_o,
  output fan_duty_t fan_sw_sync_o
);

  // pins and switches share one chain
  localparam int SyncW = NumGpio + $bits(fan_duty_t);

  // stage 0 samples the board pins, last stage is safe to use
  logic [SyncStages-1:0][SyncW-1:0] sync_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      // first flop may go metastable
      sync_q[0] <= {fan_sw_i, gpio_i};
      // settle through the remaining stages
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // split back into pins and switches
  assign {fan_sw_sync_o, gpio_sync_o} = sync_q[SyncStages-1];

endmodule

//--- logic/apb_reg_block.sv
`timescale 1ns/1ps

module apb_reg_block
  import board_pkg::*;
(
  input  logic      soc_clk,
  input  logic      rst_n,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  gpio_vec_t gpio_sync_i,
  input  fan_duty_t fan_sw_sync_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_oe_o
);

  //////////////////////////////
  // state and registers
  //////////////////////////////

  apb_state_t state_q, state_d;

  // gpio output and output enable
  gpio_vec_t gpio_out_q;
  gpio_vec_t gpio_en_q;

  // response captured in the wait state
  apb_data_t rdata_q, rdata_d;
  logic      err_q, err_d;

  // write commit strobes
  logic      commit;
  logic      wr_out;
  logic      wr_en;

  //////////////////////////////
  // transfer fsm
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // setup phase seen so go to the wait state
      st_idle: begin
        if (apb_req_i.psel && !apb_req_i.penable) begin
          state_d = st_wait;
        end
      end
      // first access cycle keeps pready low
      st_wait: begin
        if (apb_req_i.psel && apb_req_i.penable) begin
          state_d = st_respond;
        end else begin
          state_d = st_idle;
        end
      end
      // second access cycle completes the transfer
      st_respond: state_d = st_idle;
      default:    state_d = st_idle;
    endcase
  end

  //////////////////////////////
  // address decode
  //////////////////////////////

  // unmapped offsets and writes to read-only regs get the error word
  always_comb begin
    rdata_d = ErrVal;
    err_d   = 1'b1;
    case (apb_req_i.paddr)
      RegGpioOut: begin
        rdata_d = apb_data_t'(gpio_out_q);
        err_d   = 1'b0;
      end
      RegGpioEn: begin
        rdata_d = apb_data_t'(gpio_en_q);
        err_d   = 1'b0;
      end
      RegGpioIn: begin
        if (!apb_req_i.pwrite) begin
          rdata_d = apb_data_t'(gpio_sync_i);
          err_d   = 1'b0;
        end
      end
      RegFanDuty: begin
        if (!apb_req_i.pwrite) begin
          rdata_d = apb_data_t'(fan_sw_sync_i);
          err_d   = 1'b0;
        end
      end
      default: begin
        rdata_d = ErrVal;
        err_d   = 1'b1;
      end
    endcase
  end

  // write lands on the edge that ends the respond cycle
  assign commit = (state_q == st_respond) && apb_req_i.pwrite && !err_q;
  assign wr_out = commit && (apb_req_i.paddr == RegGpioOut);
  assign wr_en  = commit && (apb_req_i.paddr == RegGpioEn);

  //////////////////////////////
  // sequential part
  //////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= st_idle;
      err_q      <= 1'b0;
      gpio_out_q <= '0;
      gpio_en_q  <= '0;
    end else begin
      state_q <= state_d;
      // decode flag held for the respond cycle only
      err_q   <= (state_d == st_respond) && err_d;
      if (wr_out) begin
        gpio_out_q <= apb_req_i.pwdata[NumGpio-1:0];
      end
      if (wr_en) begin
        gpio_en_q <= apb_req_i.pwdata[NumGpio-1:0];
      end
    end
  end

  // read data word
  always_ff @(posedge soc_clk) begin
    if (state_q == st_wait) begin
      rdata_q <= rdata_d;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign apb_rsp_o.prdata  = rdata_q;
  assign apb_rsp_o.pready  = (state_q == st_respond);
  // flag register stays clear outside the respond cycle
  assign apb_rsp_o.pslverr = err_q;

  assign gpio_o    = gpio_out_q;
  assign gpio_oe_o = gpio_en_q;

endmodule

//--- logic/rtc_divider.sv
`timescale 1ns/1ps

module rtc_divider
  import board_pkg::*;
#(
  parameter int RtcHalfPeriod = 25
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  // counter just wide enough for the half period
  localparam int CntW = (RtcHalfPeriod > 1) ? $clog2(RtcHalfPeriod) : 1;
  localparam logic [CntW-1:0] CntMax = CntW'(RtcHalfPeriod - 1);

  logic [CntW-1:0] cnt_q;
  logic            rtc_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == CntMax) begin
      // half period done so flip the wave
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // square wave with twice the half period
  assign rtc_o = rtc_q;

endmodule

//--- logic/fan_pwm.sv
`timescale 1ns/1ps

module fan_pwm
  import board_pkg::*;
#(
  parameter int PwmPrescale = 4
) (
  input  logic      soc_clk,
  input  logic      rst_n,
  input  fan_duty_t duty_i,
  output logic      fan_pwm_o
);

  // prescaler sizing
  localparam int PreW = (PwmPrescale > 1) ? $clog2(PwmPrescale) : 1;
  localparam logic [PreW-1:0] PreMax = PreW'(PwmPrescale - 1);

  logic [PreW-1:0] pre_q, pre_d;
  // 16 steps per pwm period
  fan_duty_t       phase_q, phase_d;
  // duty held for a whole period
  fan_duty_t       duty_q, duty_d;
  logic            pwm_q, pwm_d;

  always_comb begin
    pre_d   = pre_q + 1'b1;
    phase_d = phase_q;
    duty_d  = duty_q;
    if (pre_q == PreMax) begin
      pre_d   = '0;
      // wraps 15 to 0 at the period start
      phase_d = phase_q + 4'd1;
      // new duty only at the period boundary
      if (phase_q == 4'hF) begin
        duty_d = duty_i;
      end
    end
    // compare on next values so the output lines up with the phase
    pwm_d = (phase_d < duty_d);
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= '0;
      phase_q <= '0;
      duty_q  <= '0;
      pwm_q   <= 1'b0;
    end else begin
      pre_q   <= pre_d;
      phase_q <= phase_d;
      duty_q  <= duty_d;
      pwm_q   <= pwm_d;
    end
  end

  // duty 0 never goes high
  assign fan_pwm_o = pwm_q;

endmodule

//--- logic/board_shell.sv
`timescale 1ns/1ps

module board_shell
  import board_pkg::*;
#(
  parameter int SyncStages    = 2,
  parameter int RtcHalfPeriod = 25,
  parameter int PwmPrescale   = 4
) (
  input  logic      soc_clk,
  input  logic      rst_n,
  // register bus
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  // gpio pins, pad buffers live on the board side
  input  gpio_vec_t gpio_i,
  output gpio_vec_t gpio_o,
  output gpio_vec_t gpio_oe_o,
  // fan
  input  fan_duty_t fan_sw_i,
  output logic      fan_pwm_o,
  // real time clock tick
  output logic      rtc_o
);

  // synchronized board inputs
  gpio_vec_t gpio_sync;
  fan_duty_t fan_sw_sync;

  //////////////////////////////
  // input side
  //////////////////////////////

  gpio_sync #(
    .SyncStages    ( SyncStages  )
  ) i_gpio_sync (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .gpio_i        ( gpio_i      ),
    .fan_sw_i      ( fan_sw_i    ),
    .gpio_sync_o   ( gpio_sync   ),
    .fan_sw_sync_o ( fan_sw_sync )
  );

  //////////////////////////////
  // register block
  //////////////////////////////

  apb_reg_block i_apb_reg_block (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .apb_req_i     ( apb_req_i   ),
    .apb_rsp_o     ( apb_rsp_o   ),
    .gpio_sync_i   ( gpio_sync   ),
    .fan_sw_sync_i ( fan_sw_sync ),
    .gpio_o        ( gpio_o      ),
    .gpio_oe_o     ( gpio_oe_o   )
  );

  //////////////////////////////
  // generators
  //////////////////////////////

  // 1 MHz from 50 MHz with the default
  rtc_divider #(
    .RtcHalfPeriod ( RtcHalfPeriod )
  ) i_rtc_divider (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_n         ),
    .rtc_o         ( rtc_o         )
  );

  // switches set the fan duty directly
  fan_pwm #(
    .PwmPrescale ( PwmPrescale )
  ) i_fan_pwm (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .duty_i      ( fan_sw_sync ),
    .fan_pwm_o   ( fan_pwm_o   )
  );

endmodule

//--- testbench/board_shell_properties.sv
`timescale 1ns/1ps

module board_shell_properties
  import board_pkg::*;
(
  input logic      soc_clk,
  input logic      rst_n,
  input apb_req_t  apb_req_i,
  input apb_rsp_t  apb_rsp_o,
  input gpio_vec_t gpio_oe_o
);

  //////////////////////////////
  // apb handshake
  //////////////////////////////

  // pready only inside an access phase
  pready_in_access: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable)
  ) else $error("pready high outside of an apb access phase");

  // error flag never without pready
  slverr_with_ready: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    apb_rsp_o.pslverr |-> apb_rsp_o.pready
  ) else $error("pslverr high without pready");

  //////////////////////////////
  // reset
  //////////////////////////////

  // pads must stay tristated in reset
  oe_off_in_reset: assert property (
    @(posedge soc_clk)
    !rst_n |-> (gpio_oe_o == '0)
  ) else $error("gpio output enable active during reset");

endmodule

bind apb_reg_block board_shell_properties i_board_shell_properties (
  .soc_clk   ( soc_clk   ),
  .rst_n     ( rst_n     ),
  .apb_req_i ( apb_req_i ),
  .apb_rsp_o ( apb_rsp_o ),
  .gpio_oe_o ( gpio_oe_o )
);

//--- testbench/tb_board_shell.sv
`timescale 1ns/1ps

module tb_board_shell
  import board_pkg::*;
();

  localparam int SyncStages    = 2;
  localparam int RtcHalfPeriod = 5;
  localparam int PwmPrescale   = 2;
  localparam int PwmPeriod     = 16 * PwmPrescale;

  logic      soc_clk;
  logic      rst_n;
  apb_req_t  req;
  apb_rsp_t  rsp;
  gpio_vec_t gpio_in;
  gpio_vec_t gpio_out;
  gpio_vec_t gpio_oe;
  fan_duty_t fan_sw;
  logic      fan_pwm;
  logic      rtc;

  int          err_cnt;
  logic [15:0] lfsr_q;

  // shadow of the writable registers
  apb_data_t exp_out;
  apb_data_t exp_en;
  apb_data_t gpio_mask;

  // one stimulus row
  typedef struct {
    string     name;
    bit        wr;
    apb_addr_t addr;
    apb_data_t wdata;
    bit        rnd;
    gpio_vec_t gpio_val;
    fan_duty_t fan_val;
    bit        use_model;
    apb_data_t exp_rdata;
    bit        exp_err;
  } row_t;

  row_t rows[$];

  board_shell #(
    .SyncStages    ( SyncStages    ),
    .RtcHalfPeriod ( RtcHalfPeriod ),
    .PwmPrescale   ( PwmPrescale   )
  ) dut0 (
    .soc_clk   ( soc_clk  ),
    .rst_n     ( rst_n    ),
    .apb_req_i ( req      ),
    .apb_rsp_o ( rsp      ),
    .gpio_i    ( gpio_in  ),
    .gpio_o    ( gpio_out ),
    .gpio_oe_o ( gpio_oe  ),
    .fan_sw_i  ( fan_sw   ),
    .fan_pwm_o ( fan_pwm  ),
    .rtc_o     ( rtc      )
  );

  // 100 ns clock
  initial begin
    soc_clk = 1'b0;
    forever #50 soc_clk = ~soc_clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(input int n, output apb_data_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic compare_word(input string name, input apb_data_t exp, input apb_data_t act);
    assert (exp === act) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_row(input string name, input bit wr, input apb_addr_t addr,
                         input apb_data_t wdata, input bit rnd, input gpio_vec_t gpio_val,
                         input fan_duty_t fan_val, input bit use_model,
                         input apb_data_t exp_rdata, input bit exp_err);
    row_t r;
    r = '{name, wr, addr, wdata, rnd, gpio_val, fan_val, use_model, exp_rdata, exp_err};
    rows.push_back(r);
  endtask

  // setup, access, then wait for pready
  task automatic apb_xfer(input bit wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    int waited;
    rdata = '0;
    err   = 1'b0;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.paddr   = addr;
    req.pwdata  = wdata;
    @(posedge soc_clk);
    #5;
    req.penable = 1'b1;
    waited = 0;
    // pready sampled mid cycle, away from the edge
    while (waited < 10) begin
      @(negedge soc_clk);
      if (rsp.pready) begin
        break;
      end
      waited++;
    end
    if (waited >= 10) begin
      $display("apb transfer to offset %h never got pready", addr);
      err_cnt++;
    end else begin
      rdata = rsp.prdata;
      err   = rsp.pslverr;
    end
    @(posedge soc_clk);
    #5;
    req.psel    = 1'b0;
    req.penable = 1'b0;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    apb_data_t rdata;
    apb_data_t wdata;
    apb_data_t exp;
    logic      err;
    int        cnt;
    int        waited;
    logic      prev;
    fan_duty_t duties[3];

    err_cnt   = 0;
    lfsr_q    = 16'd21595;
    exp_out   = '0;
    exp_en    = '0;
    gpio_mask = apb_data_t'({NumGpio{1'b1}});
    rst_n     = 1'b0;
    req       = '0;
    gpio_in   = '0;
    fan_sw    = '0;

    // name wr addr wdata rnd gpio fan model exp err
    add_row("reset_rd_out", 0, RegGpioOut, 0, 0, '0, 4'h0, 0, 32'h0, 0);
    add_row("wr_out",       1, RegGpioOut, 0, 1, '0, 4'h0, 0, 32'h0, 0);
    add_row("wr_en",        1, RegGpioEn,  0, 1, '0, 4'h0, 0, 32'h0, 0);
    add_row("rd_out",       0, RegGpioOut, 0, 0, '0, 4'h0, 1, 32'h0, 0);
    add_row("rd_en",        0, RegGpioEn,  0, 0, '0, 4'h0, 1, 32'h0, 0);
    add_row("rd_in",        0, RegGpioIn,  0, 1, '0, 4'h0, 1, 32'h0, 0);
    add_row("rd_fan",       0, RegFanDuty, 0, 0, '0, 4'hA, 0, 32'hA, 0);
    add_row("rd_unmapped",  0, 12'h010,    0, 0, '0, 4'h0, 0, ErrVal, 1);
    add_row("wr_in_ro",     1, RegGpioIn,  32'hFFFFFFFF, 0, '0, 4'h0, 0, ErrVal, 1);
    add_row("rd_out_kept",  0, RegGpioOut, 0, 0, '0, 4'h0, 1, 32'h0, 0);

    repeat (4) @(posedge soc_clk);
    #5;
    rst_n = 1'b1;

    // reset values of the outputs
    compare_word("reset_gpio_o", '0, apb_data_t'(gpio_out));
    compare_word("reset_gpio_oe", '0, apb_data_t'(gpio_oe));
    compare_word("reset_rtc", '0, apb_data_t'(rtc));
    compare_word("reset_fan", '0, apb_data_t'(fan_pwm));

    foreach (rows[i]) begin
      wdata   = rows[i].wdata;
      gpio_in = rows[i].gpio_val;
      fan_sw  = rows[i].fan_val;
      if (rows[i].rnd) begin
        if (rows[i].wr) begin
          draw_bits(32, wdata);
        end else begin
          draw_bits(NumGpio, exp);
          gpio_in = exp[NumGpio-1:0];
        end
      end
      // let the pins pass the synchronizer
      repeat (SyncStages + 1) @(posedge soc_clk);
      #5;
      apb_xfer(rows[i].wr, rows[i].addr, wdata, rdata, err);
      compare_word({rows[i].name, "_err"}, apb_data_t'(rows[i].exp_err), apb_data_t'(err));
      if (rows[i].wr && !rows[i].exp_err) begin
        // model the accepted write
        if (rows[i].addr == RegGpioOut) begin
          exp_out = wdata & gpio_mask;
          compare_word({rows[i].name, "_pin"}, exp_out, apb_data_t'(gpio_out));
        end else begin
          exp_en = wdata & gpio_mask;
          compare_word({rows[i].name, "_pin"}, exp_en, apb_data_t'(gpio_oe));
        end
      end else if (!rows[i].wr || rows[i].exp_err) begin
        exp = rows[i].exp_rdata;
        if (rows[i].use_model) begin
          case (rows[i].addr)
            RegGpioOut: exp = exp_out;
            RegGpioEn:  exp = exp_en;
            default:    exp = apb_data_t'(gpio_in);
          endcase
        end
        compare_word(rows[i].name, exp, rdata);
      end
    end

    //////////////////////////////
    // rtc period
    //////////////////////////////

    cnt    = 0;
    waited = 0;
    prev   = rtc;
    // find the first rising edge
    while (waited < 4 * RtcHalfPeriod && !(!prev && rtc)) begin
      prev = rtc;
      @(negedge soc_clk);
      waited++;
    end
    if (waited >= 4 * RtcHalfPeriod) begin
      $display("rtc output never rose");
      err_cnt++;
    end else begin
      prev = rtc;
      while (cnt < 4 * RtcHalfPeriod) begin
        @(negedge soc_clk);
        cnt++;
        if (!prev && rtc) begin
          break;
        end
        prev = rtc;
      end
      compare_word("rtc_period", 2 * RtcHalfPeriod, cnt);
    end

    //////////////////////////////
    // fan pwm duty
    //////////////////////////////

    duties = '{4'd0, 4'd5, 4'd15};
    foreach (duties[d]) begin
      @(posedge soc_clk);
      #5;
      fan_sw = duties[d];
      // two periods to settle
      repeat (2 * PwmPeriod) @(posedge soc_clk);
      cnt = 0;
      repeat (PwmPeriod) begin
        @(negedge soc_clk);
        if (fan_pwm) begin
          cnt++;
        end
      end
      compare_word($sformatf("fan_duty_%0d", duties[d]), duties[d] * PwmPrescale, cnt);
    end

    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- board_shell.f
logic/board_pkg.sv
logic/gpio_sync.sv
logic/apb_reg_block.sv
logic/rtc_divider.sv
logic/fan_pwm.sv
logic/board_shell.sv
testbench/board_shell_properties.sv
testbench/tb_board_shell.sv

//--- Makefile
# Verilator flow for the board shell

VERILATOR ?= verilator
TOP       ?= tb_board_shell
RTL_TOP   ?= board_shell
FILELIST  ?= board_shell.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

# lint the design on its own, then the full testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		logic/board_pkg.sv logic/gpio_sync.sv logic/apb_reg_block.sv \
		logic/rtc_divider.sv logic/fan_pwm.sv logic/board_shell.sv
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR)

# pass only if the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
